// ==== apu_dispatcher.sv ====
// APU dispatcher: outstanding slots, dependency verdicts, stalls and destination return
module apu_dispatcher
  import apu_pkg::*;
#(
  parameter int unsigned RegAw = REG_AW
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Request from the issue stage
  input  logic                    enable_i,
  input  apu_lat_e                apu_lat_i,
  input  logic [RegAw-1:0]        apu_waddr_i,
  // Dependency inputs
  input  logic                    is_decoding_i,
  input  logic [2:0][RegAw-1:0]   read_regs_i,
  input  logic [2:0]              read_regs_valid_i,
  input  logic [RegAw-1:0]        write_regs_i,
  input  logic                    write_regs_valid_i,
  // Execution unit handshake
  input  logic                    apu_gnt_i,
  input  logic                    apu_rvalid_i,
  output logic                    apu_req_o,
  // Destination of the returning result
  output logic [RegAw-1:0]        apu_waddr_o,
  // Status and verdicts
  output logic                    active_o,
  output logic                    stall_o,
  output logic                    read_dep_o,
  output logic                    write_dep_o,
  // Performance strobes
  output logic                    perf_type_o,
  output logic                    perf_cont_o
);

  // Number of occupied slots
  typedef enum logic [1:0] {
    SLOTS_EMPTY,
    SLOTS_ONE,
    SLOTS_TWO
  } slot_occ_e;

  logic [RegAw-1:0] addr_inflight_q, addr_waiting_q;
  logic [RegAw-1:0] addr_inflight_d, addr_waiting_d;
  logic             valid_inflight_q, valid_waiting_q;
  logic             valid_inflight_d, valid_waiting_d;
  logic             valid_req, req_accepted;
  logic             returned_req, returned_inflight, returned_waiting;
  apu_lat_e         lat_q;
  slot_occ_e        slot_occ;
  logic [2:0]       read_deps_inflight, read_deps_waiting;
  logic             stall_full, stall_type, stall_nack;

  // No request goes out under a full or type stall
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign req_accepted = valid_req & apu_gnt_i;

  ////////////////////////////////////////
  // Outstanding slots
  ////////////////////////////////////////

  // Oldest outstanding operation returns first
  assign returned_req      = req_accepted & apu_rvalid_i & ~valid_inflight_q & ~valid_waiting_q;
  assign returned_inflight = valid_inflight_q & apu_rvalid_i & ~valid_waiting_q;
  assign returned_waiting  = valid_waiting_q & apu_rvalid_i;

  always_comb begin
    valid_inflight_d = valid_inflight_q;
    valid_waiting_d  = valid_waiting_q;
    addr_inflight_d  = addr_inflight_q;
    addr_waiting_d   = addr_waiting_q;
    if (req_accepted && !returned_req) begin
      // New operation becomes the in-flight one
      valid_inflight_d = 1'b1;
      addr_inflight_d  = apu_waddr_i;
      // Older one moves to waiting unless it leaves now
      if ((valid_inflight_q && !returned_inflight) || returned_waiting) begin
        valid_waiting_d = 1'b1;
        addr_waiting_d  = addr_inflight_q;
      end
    end else if (returned_inflight) begin
      valid_inflight_d = 1'b0;
      valid_waiting_d  = 1'b0;
    end else if (returned_waiting) begin
      valid_waiting_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight_q <= 1'b0;
      valid_waiting_q  <= 1'b0;
      addr_inflight_q  <= '0;
      addr_waiting_q   <= '0;
      lat_q            <= LAT_SAME;
    end else begin
      valid_inflight_q <= valid_inflight_d;
      valid_waiting_q  <= valid_waiting_d;
      addr_inflight_q  <= addr_inflight_d;
      addr_waiting_q   <= addr_waiting_d;
      // Class of the youngest accepted request
      if (req_accepted) begin
        lat_q <= apu_lat_i;
      end
    end
  end

  // Waiting slot only fills behind the in-flight one
  always_comb begin
    if (valid_waiting_q) begin
      slot_occ = SLOTS_TWO;
    end else if (valid_inflight_q) begin
      slot_occ = SLOTS_ONE;
    end else begin
      slot_occ = SLOTS_EMPTY;
    end
  end

  assign active_o = (slot_occ != SLOTS_EMPTY);

  ////////////////////////////////////////
  // Dependencies
  ////////////////////////////////////////

  // No forwarding, so a slot counts until its value sits in the register file
  for (genvar i = 0; i < 3; i++) begin : gen_read_dep
    assign read_deps_inflight[i] = read_regs_valid_i[i] & valid_inflight_q &
                                   (read_regs_i[i] == addr_inflight_q);
    assign read_deps_waiting[i]  = read_regs_valid_i[i] & valid_waiting_q &
                                   (read_regs_i[i] == addr_waiting_q);
  end

  assign read_dep_o  = is_decoding_i & (|read_deps_inflight | |read_deps_waiting);
  assign write_dep_o = is_decoding_i & write_regs_valid_i &
                       ((valid_inflight_q & (write_regs_i == addr_inflight_q)) |
                        (valid_waiting_q & (write_regs_i == addr_waiting_q)));

  ////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////

  assign stall_full = (slot_occ == SLOTS_TWO);
  // Only a two-stage op may follow a one or two stage op, else results overtake
  assign stall_type = enable_i & active_o &
                      ((apu_lat_i == LAT_SAME) | (apu_lat_i == LAT_ONE) |
                       (apu_lat_i == LAT_MULTI) |
                       ((apu_lat_i == LAT_TWO) & (lat_q == LAT_MULTI)));
  // Unit refused, divider still busy
  assign stall_nack = valid_req & ~apu_gnt_i;
  assign stall_o    = stall_full | stall_type | stall_nack;

  assign apu_req_o   = valid_req;
  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  // Destination follows the slot the result belongs to
  always_comb begin
    apu_waddr_o = apu_waddr_i;
    if (returned_inflight) begin
      apu_waddr_o = addr_inflight_q;
    end
    if (returned_waiting) begin
      apu_waddr_o = addr_waiting_q;
    end
  end

  // Execution unit answers only for operations this dispatcher sent
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    apu_rvalid_i |-> (returned_req | returned_inflight | returned_waiting))
    else $error("result returned with nothing outstanding");

  // Slots never hold more than two operations
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_waiting_q |-> valid_inflight_q)
    else $error("waiting slot occupied without an in-flight operation");

endmodule

// ==== apu_exec_unit.sv ====
// APU execution unit: same-cycle add, pipelined multiply and MAC, restoring divider
module apu_exec_unit
  import apu_pkg::*;
#(
  parameter int unsigned DataW     = DATA_W,
  parameter int unsigned DivCycles = 16
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  apu_req_t          req_data_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DataW-1:0]  result_o
);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

  // Counter reaches DivCycles on the result cycle
  localparam int unsigned CntW = $clog2(DivCycles + 1);

  logic             same_vld, mul_vld_q, mac_vld1_q, mac_vld2_q, div_vld, div_start;
  logic [DataW-1:0] same_res, mul_res_q, mac_prod_q, mac_c_q, mac_res_q;
  logic [DataW-1:0] div_quo_q, div_rem_q, div_dsr_q;
  logic [DataW:0]   rem_shift, rem_diff;
  logic [CntW-1:0]  div_cnt_q;
  div_state_e       div_state_q;

  // Divide waits for an idle divider, the rest goes at once
  assign gnt_o     = req_i & ((req_data_i.op != OP_DIV) | (div_state_q == DIV_IDLE));
  assign div_start = gnt_o & (req_data_i.op == OP_DIV);

  ////////////////////////////////////////
  // Same-cycle and pipelined paths
  ////////////////////////////////////////

  assign same_vld = gnt_o & ((req_data_i.op == OP_LDI) | (req_data_i.op == OP_ADD));
  assign same_res = (req_data_i.op == OP_LDI) ? req_data_i.opa
                                              : req_data_i.opa + req_data_i.opb;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mul_vld_q  <= 1'b0;
      mac_vld1_q <= 1'b0;
      mac_vld2_q <= 1'b0;
    end else begin
      mul_vld_q  <= gnt_o & (req_data_i.op == OP_MUL);
      mac_vld1_q <= gnt_o & (req_data_i.op == OP_MAC);
      mac_vld2_q <= mac_vld1_q;
    end
  end

  // Product kept to datapath width, wraps like the adder
  always_ff @(posedge clk_i) begin
    mul_res_q  <= req_data_i.opa * req_data_i.opb;
    mac_prod_q <= req_data_i.opa * req_data_i.opb;
    mac_c_q    <= req_data_i.opc;
    mac_res_q  <= mac_prod_q + mac_c_q;
  end

  ////////////////////////////////////////
  // Restoring divider
  ////////////////////////////////////////

  // One quotient bit per cycle, remainder one bit wider for the trial subtract
  assign rem_shift = {div_rem_q, div_quo_q[DataW-1]};
  assign rem_diff  = rem_shift - {1'b0, div_dsr_q};
  assign div_vld   = (div_state_q == DIV_RUN) & (div_cnt_q == CntW'(DivCycles));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_state_q <= DIV_IDLE;
      div_cnt_q   <= '0;
    end else begin
      unique case (div_state_q)
        DIV_IDLE: begin
          if (div_start) begin
            div_state_q <= DIV_RUN;
            div_cnt_q   <= '0;
          end
        end
        DIV_RUN: begin
          if (div_vld) begin
            div_state_q <= DIV_DONE;
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        // Recovery cycle, next divide is refused here
        DIV_DONE: div_state_q <= DIV_IDLE;
        default:  div_state_q <= DIV_IDLE;
      endcase
    end
  end

  // Zero divisor never borrows and so yields all ones
  always_ff @(posedge clk_i) begin
    if (div_start) begin
      div_quo_q <= req_data_i.opa;
      div_dsr_q <= req_data_i.opb;
      div_rem_q <= '0;
    end else if ((div_state_q == DIV_RUN) && (div_cnt_q < CntW'(DataW))) begin
      if (!rem_diff[DataW]) begin
        div_rem_q <= rem_diff[DataW-1:0];
        div_quo_q <= {div_quo_q[DataW-2:0], 1'b1};
      end else begin
        div_rem_q <= rem_shift[DataW-1:0];
        div_quo_q <= {div_quo_q[DataW-2:0], 1'b0};
      end
    end
  end

  ////////////////////////////////////////
  // Result return
  ////////////////////////////////////////

  assign rvalid_o = same_vld | mul_vld_q | mac_vld2_q | div_vld;

  always_comb begin
    result_o = same_res;
    if (mul_vld_q) begin
      result_o = mul_res_q;
    end
    if (mac_vld2_q) begin
      result_o = mac_res_q;
    end
    if (div_vld) begin
      result_o = div_quo_q;
    end
  end

  // The dispatcher type stall keeps the return paths apart
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({same_vld, mul_vld_q, mac_vld2_q, div_vld}))
    else $error("two result sources returned in the same cycle");

endmodule

// ==== apu_issue_stage.sv ====
// APU issue stage: opcode decode, operand read, dependency gating and request payload
module apu_issue_stage
  import apu_pkg::*;
#(
  parameter int unsigned RegAw = REG_AW,
  parameter int unsigned DataW = DATA_W
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Instruction, held by the outside until taken
  input  logic                    instr_valid_i,
  input  apu_instr_t              instr_i,
  // Operands from the register file
  input  logic [2:0][DataW-1:0]   rd_data_i,
  // Verdicts from the dispatcher
  input  logic                    read_dep_i,
  input  logic                    write_dep_i,
  input  logic                    stall_i,
  // Grant from the execution unit
  input  logic                    gnt_i,
  // Towards the dispatcher
  output logic                    enable_o,
  output apu_lat_e                lat_o,
  output logic [RegAw-1:0]        waddr_o,
  output logic [2:0][RegAw-1:0]   read_regs_o,
  output logic [2:0]              read_regs_valid_o,
  output logic [RegAw-1:0]        write_regs_o,
  output logic                    write_regs_valid_o,
  output logic                    is_decoding_o,
  // Register file read addresses
  output logic [2:0][RegAw-1:0]   rd_addr_o,
  // Payload for the execution unit
  output apu_req_t                req_o,
  output logic                    instr_taken_o
);

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Latency class and used sources per opcode
  always_comb begin
    lat_o             = LAT_SAME;
    read_regs_valid_o = 3'b000;
    unique case (instr_i.op)
      OP_LDI: begin
        lat_o             = LAT_SAME;
        read_regs_valid_o = 3'b000;
      end
      OP_ADD: begin
        lat_o             = LAT_SAME;
        read_regs_valid_o = 3'b011;
      end
      OP_MUL: begin
        lat_o             = LAT_ONE;
        read_regs_valid_o = 3'b011;
      end
      OP_MAC: begin
        lat_o             = LAT_TWO;
        read_regs_valid_o = 3'b111;
      end
      OP_DIV: begin
        lat_o             = LAT_MULTI;
        read_regs_valid_o = 3'b011;
      end
      default: begin
        lat_o             = LAT_SAME;
        read_regs_valid_o = 3'b000;
      end
    endcase
  end

  // Sources in port order A, B, C
  assign rd_addr_o   = {instr_i.rs_c, instr_i.rs_b, instr_i.rs_a};
  assign read_regs_o = rd_addr_o;

  // Every opcode writes its destination
  assign waddr_o            = instr_i.rd;
  assign write_regs_o       = instr_i.rd;
  assign write_regs_valid_o = instr_valid_i;
  assign is_decoding_o      = instr_valid_i;

  ////////////////////////////////////////
  // Request
  ////////////////////////////////////////

  // Held back while a source or the destination is still outstanding
  assign enable_o = instr_valid_i & ~read_dep_i & ~write_dep_i;

  // Immediate takes the place of operand A for load immediate
  assign req_o.op  = instr_i.op;
  assign req_o.opa = (instr_i.op == OP_LDI) ? instr_i.imm : rd_data_i[0];
  assign req_o.opb = rd_data_i[1];
  assign req_o.opc = rd_data_i[2];

  // Stall already folds in a missing grant
  assign instr_taken_o = enable_o & ~stall_i;

  // Dispatcher stall and unit grant have to agree on every accepted request
  assert property (@(posedge clk_i) disable iff (!rst_ni) instr_taken_o |-> gnt_i)
    else $error("instruction taken without a grant from the execution unit");

endmodule

// ==== apu_pkg.sv ====
// APU package with opcodes, latency classes and the instruction, request and writeback structs
package apu_pkg;

  ////////////////////////////////////////
  // Default widths
  ////////////////////////////////////////

  // Register address width, sixteen registers
  localparam int unsigned REG_AW = 4;
  // Datapath width of operands and results
  localparam int unsigned DATA_W = 16;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Opcodes of the five supported operations
  typedef enum logic [2:0] {
    OP_LDI = 3'd0,
    OP_ADD = 3'd1,
    OP_MUL = 3'd2,
    OP_MAC = 3'd3,
    OP_DIV = 3'd4
  } apu_op_e;

  // Latency classes, ordered by how long a result takes
  typedef enum logic [1:0] {
    LAT_SAME  = 2'd0,
    LAT_ONE   = 2'd1,
    LAT_TWO   = 2'd2,
    LAT_MULTI = 2'd3
  } apu_lat_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Instruction as held by the outside
  typedef struct packed {
    apu_op_e           op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs_a;
    logic [REG_AW-1:0] rs_b;
    logic [REG_AW-1:0] rs_c;
    logic [DATA_W-1:0] imm;
  } apu_instr_t;

  // Request to the execution unit, operands already read
  typedef struct packed {
    apu_op_e           op;
    logic [DATA_W-1:0] opa;
    logic [DATA_W-1:0] opb;
    logic [DATA_W-1:0] opc;
  } apu_req_t;

  // Writeback report
  typedef struct packed {
    logic [REG_AW-1:0] addr;
    logic [DATA_W-1:0] data;
  } apu_wb_t;

endpackage

// ==== apu_subsys_top.sv ====
// APU subsystem top: issue stage, dispatcher, execution unit and writeback
module apu_subsys_top
  import apu_pkg::*;
#(
  parameter int unsigned RegAw     = REG_AW,
  parameter int unsigned DataW     = DATA_W,
  parameter int unsigned DivCycles = 16
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        instr_valid_i,
  input  apu_instr_t  instr_i,
  output logic        instr_taken_o,
  output logic        wb_valid_o,
  output apu_wb_t     wb_o,
  output logic        busy_o,
  output logic        perf_type_o,
  output logic        perf_cont_o
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  logic                  enable, is_decoding, read_dep, write_dep, stall;
  logic                  write_regs_valid, apu_req, apu_gnt, result_valid;
  apu_lat_e              lat;
  logic [RegAw-1:0]      issue_waddr, write_regs, ret_waddr;
  logic [2:0][RegAw-1:0] read_regs, rd_addr;
  logic [2:0]            read_regs_valid;
  logic [2:0][DataW-1:0] rd_data;
  logic [DataW-1:0]      result;
  apu_req_t              req_data;

  apu_issue_stage #(
    .RegAw (RegAw),
    .DataW (DataW)
  ) u_issue (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .instr_i            (instr_i),
    .rd_data_i          (rd_data),
    .read_dep_i         (read_dep),
    .write_dep_i        (write_dep),
    .stall_i            (stall),
    .gnt_i              (apu_gnt),
    .enable_o           (enable),
    .lat_o              (lat),
    .waddr_o            (issue_waddr),
    .read_regs_o        (read_regs),
    .read_regs_valid_o  (read_regs_valid),
    .write_regs_o       (write_regs),
    .write_regs_valid_o (write_regs_valid),
    .is_decoding_o      (is_decoding),
    .rd_addr_o          (rd_addr),
    .req_o              (req_data),
    .instr_taken_o      (instr_taken_o)
  );

  apu_dispatcher #(
    .RegAw (RegAw)
  ) u_disp (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .enable_i           (enable),
    .apu_lat_i          (lat),
    .apu_waddr_i        (issue_waddr),
    .is_decoding_i      (is_decoding),
    .read_regs_i        (read_regs),
    .read_regs_valid_i  (read_regs_valid),
    .write_regs_i       (write_regs),
    .write_regs_valid_i (write_regs_valid),
    .apu_gnt_i          (apu_gnt),
    .apu_rvalid_i       (result_valid),
    .apu_req_o          (apu_req),
    .apu_waddr_o        (ret_waddr),
    .active_o           (busy_o),
    .stall_o            (stall),
    .read_dep_o         (read_dep),
    .write_dep_o        (write_dep),
    .perf_type_o        (perf_type_o),
    .perf_cont_o        (perf_cont_o)
  );

  apu_exec_unit #(
    .DataW     (DataW),
    .DivCycles (DivCycles)
  ) u_exec (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (apu_req),
    .req_data_i (req_data),
    .gnt_o      (apu_gnt),
    .rvalid_o   (result_valid),
    .result_o   (result)
  );

  apu_writeback #(
    .RegAw (RegAw),
    .DataW (DataW)
  ) u_wb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rvalid_i   (result_valid),
    .waddr_i    (ret_waddr),
    .result_i   (result),
    .rd_addr_i  (rd_addr),
    .rd_data_o  (rd_data),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o)
  );

endmodule

// ==== apu_writeback.sv ====
// APU writeback: register file with three read ports and the registered writeback report
module apu_writeback
  import apu_pkg::*;
#(
  parameter int unsigned RegAw = REG_AW,
  parameter int unsigned DataW = DATA_W
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Returning result
  input  logic                    rvalid_i,
  input  logic [RegAw-1:0]        waddr_i,
  input  logic [DataW-1:0]        result_i,
  // Operand reads for the issue stage
  input  logic [2:0][RegAw-1:0]   rd_addr_i,
  output logic [2:0][DataW-1:0]   rd_data_o,
  // Report
  output logic                    wb_valid_o,
  output apu_wb_t                 wb_o
);

  logic [DataW-1:0] rf_q [2**RegAw];

  // Register file comes out of reset as all zeros
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 2**RegAw; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rvalid_i) begin
      rf_q[waddr_i] <= result_i;
    end
  end

  // Asynchronous reads
  for (genvar i = 0; i < 3; i++) begin : gen_read
    assign rd_data_o[i] = rf_q[rd_addr_i[i]];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= rvalid_i;
    end
  end

  // Report lands together with the register file write
  always_ff @(posedge clk_i) begin
    if (rvalid_i) begin
      wb_o.addr <= waddr_i;
      wb_o.data <= result_i;
    end
  end

endmodule

// ==== build.f ====
apu_pkg.sv
apu_issue_stage.sv
apu_dispatcher.sv
apu_exec_unit.sv
apu_writeback.sv
apu_subsys_top.sv
tb_apu_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the APU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module tb_apu_subsys -f build.f -o sim_apu

./obj_dir/sim_apu > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
grep -q "all tests passed" sim.log

// ==== tb_apu_subsys.sv ====
// Testbench for the APU subsystem: clock, reset, random stimulus, reference model and checks
module tb_apu_subsys
  import apu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned DIV_CYCLES = 16;
  localparam int unsigned RST_CYCLES = 16;
  localparam int unsigned NUM_INSTR  = 200;
  // Worst case per instruction is one divide plus its recovery
  localparam int unsigned CYCLE_LIMIT = NUM_INSTR * (DIV_CYCLES + 4) + RST_CYCLES;
  // Two slots, each at most one divide long
  localparam int unsigned DRAIN_LIMIT = 2 * (DIV_CYCLES + 4);

  logic       clk_i;
  logic       rst_ni;
  logic       instr_valid_i;
  apu_instr_t instr_i;
  logic       instr_taken_o;
  logic       wb_valid_o;
  apu_wb_t    wb_o;
  logic       busy_o;
  logic       perf_type_o;
  logic       perf_cont_o;

  apu_subsys_top #(
    .RegAw     (REG_AW),
    .DataW     (DATA_W),
    .DivCycles (DIV_CYCLES)
  ) UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_taken_o (instr_taken_o),
    .wb_valid_o    (wb_valid_o),
    .wb_o          (wb_o),
    .busy_o        (busy_o),
    .perf_type_o   (perf_type_o),
    .perf_cont_o   (perf_cont_o)
  );

  int unsigned      cycles;
  int unsigned      mismatch_errs;
  int unsigned      other_errs;
  logic [DATA_W-1:0] shadow_rf [16];
  apu_wb_t          exp_q [$];
  logic             seen_cont, seen_type;
  logic             have_prev, busy_prev;
  int               cand_prev;

  ////////////////////////////////////////
  // Clock, reset and run limit
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Run limit derived from the test length
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d writebacks still expected", cycles, exp_q.size());
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reset behavior
  ////////////////////////////////////////

  // Outputs quiet while reset is held
  assert property (@(posedge clk_i) !rst_ni |->
    !(instr_taken_o | wb_valid_o | busy_o | perf_type_o | perf_cont_o))
    else begin
      other_errs++;
      $display("outputs active while reset is held");
    end

  // And still quiet on the first cycle out of reset
  assert property (@(posedge clk_i) $rose(rst_ni) |->
    !(instr_taken_o | wb_valid_o | busy_o | perf_type_o | perf_cont_o))
    else begin
      other_errs++;
      $display("outputs active right after reset release");
    end

  ////////////////////////////////////////
  // Reference model and scoreboard
  ////////////////////////////////////////

  function automatic logic [DATA_W-1:0] ref_result(apu_instr_t ins);
    logic [DATA_W-1:0] a, b, c;
    a = shadow_rf[ins.rs_a];
    b = shadow_rf[ins.rs_b];
    c = shadow_rf[ins.rs_c];
    case (ins.op)
      OP_LDI:  return ins.imm;
      OP_ADD:  return a + b;
      OP_MUL:  return a * b;
      OP_MAC:  return (a * b) + c;
      // Divide by zero gives all ones
      OP_DIV:  return (b == '0) ? '1 : a / b;
      default: return '0;
    endcase
  endfunction

  always @(posedge clk_i) begin
    apu_wb_t exp;
    int      n;
    if (rst_ni) begin
      if (perf_cont_o) seen_cont = 1'b1;
      if (perf_type_o) seen_type = 1'b1;
      // Operations inside the unit last cycle must have shown up as busy
      if (have_prev && (cand_prev - int'(wb_valid_o)) > 0) begin
        assert (busy_prev) else begin
          other_errs++;
          $display("busy was low while an operation was still in the unit");
        end
      end
      n         = exp_q.size();
      cand_prev = n - int'(wb_valid_o);
      busy_prev = busy_o;
      have_prev = 1'b1;
      // Pop before push, results leave in issue order
      if (wb_valid_o) begin
        assert (exp_q.size() != 0) else begin
          other_errs++;
          $display("writeback reported with no instruction outstanding");
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          assert (wb_o == exp) else begin
            mismatch_errs++;
            $display("mismatch writeback expected %h:%h actual %h:%h",
                     exp.addr, exp.data, wb_o.addr, wb_o.data);
          end
        end
      end
      if (instr_taken_o) begin
        exp.addr = instr_i.rd;
        exp.data = ref_result(instr_i);
        shadow_rf[instr_i.rd] = exp.data;
        exp_q.push_back(exp);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  function automatic apu_instr_t make_instr(apu_op_e op, int rd, int a, int b, int c,
                                            logic [DATA_W-1:0] imm);
    apu_instr_t ins;
    ins.op   = op;
    ins.rd   = REG_AW'(rd);
    ins.rs_a = REG_AW'(a);
    ins.rs_b = REG_AW'(b);
    ins.rs_c = REG_AW'(c);
    ins.imm  = imm;
    return ins;
  endfunction

  // Drives on a falling edge and holds the instruction until the DUT takes it
  // Next instruction follows on the falling edge right after the taken cycle
  task automatic issue_instr(apu_instr_t ins);
    instr_valid_i = 1'b1;
    instr_i       = ins;
    do @(posedge clk_i); while (!instr_taken_o);
    @(negedge clk_i);
  endtask

  function automatic apu_instr_t random_instr(int prev_rd, logic chain);
    apu_instr_t ins;
    // Register 15 is never written and stays a zero divisor
    ins = make_instr(apu_op_e'($urandom % 5), $urandom % 15, $urandom % 16,
                     $urandom % 16, $urandom % 16, DATA_W'($urandom));
    // Chain reads or rewrites the previous destination
    if (chain) begin
      if ($urandom % 2) ins.rs_a = REG_AW'(prev_rd);
      else ins.rd = REG_AW'(prev_rd);
    end
    return ins;
  endfunction

  initial begin
    apu_instr_t  ins;
    int          prev_rd;
    int unsigned drain;
    cycles        = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    seen_cont     = 1'b0;
    seen_type     = 1'b0;
    have_prev     = 1'b0;
    busy_prev     = 1'b0;
    cand_prev     = 0;
    prev_rd       = 0;
    drain         = 0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rst_ni        = 1'b0;
    for (int i = 0; i < 16; i++) shadow_rf[i] = '0;
    void'($urandom(40786));
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);

    // Sixteen loads, register 15 kept at zero for divide by zero
    for (int i = 0; i < 16; i++) begin
      issue_instr(make_instr(OP_LDI, i, 0, 0, 0, (i == 15) ? '0 : DATA_W'($urandom)));
    end
    for (int i = 16; i < NUM_INSTR; i++) begin
      if (i == 60 || i == 140) begin
        // Back to back divides, second one by zero
        issue_instr(make_instr(OP_DIV, 1, 2, 3, 0, '0));
        issue_instr(make_instr(OP_DIV, 4, 5, 15, 0, '0));
        i++;
      end else if (i == 90 || i == 170) begin
        // Multiply right behind a MAC
        issue_instr(make_instr(OP_MAC, 6, 7, 8, 9, '0));
        issue_instr(make_instr(OP_MUL, 10, 11, 12, 0, '0));
        i++;
      end else begin
        ins = random_instr(prev_rd, (i % 4) != 0);
        issue_instr(ins);
        prev_rd = ins.rd;
      end
    end
    instr_valid_i = 1'b0;

    // Drain, bounded by the longest time two outstanding slots can take
    while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
      @(posedge clk_i);
      drain++;
    end
    repeat (4) @(posedge clk_i);
    assert (exp_q.size() == 0) else begin
      other_errs++;
      $display("writebacks still expected at the end of the run");
    end
    assert (seen_cont) else begin
      other_errs++;
      $display("divider contention strobe never seen");
    end
    assert (seen_type) else begin
      other_errs++;
      $display("type conflict strobe never seen");
    end
    $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
